// File: build.f
+incdir+common
common/isa_pkg.sv
common/ooo_pkg.sv
source/regfile.sv
rob/rob.sv
source/dispatch.sv
source/res_station.sv
source/cdb_arbiter.sv
source/ooo_core.sv
sim/ooo_core_chk.sv
sim/tb_ooo_core.sv

// File: build.sh
#!/bin/bash
# compile with Verilator, run, and decide from the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	-f build.f --top-module tb_ooo_core -o sim_ooo_core \
	&& ./obj_dir/sim_ooo_core > sim.log 2>&1 \
	; cat sim.log \
	&& grep -q "SIMULATION PASSED" sim.log \
	&& echo "run passed" \
	|| { echo "run failed"; exit 1; }

// File: sim/tb_ooo_core.sv
`timescale 1ns/1ps

`include "ooo_params.svh"

module tb_ooo_core
	import isa_pkg::*, ooo_pkg::*;
;

	localparam int TIMEOUT   = 200;
	localparam int NUM_INSTR = 300;

	typedef struct packed {
		alu_op_t  op;
		reg_idx_t rd;
		reg_idx_t rs1;
		reg_idx_t rs2;
		word_t    imm;
	} instr_t;

	logic     clk;
	logic     rst;
	logic     issue;
	alu_op_t  op;
	reg_idx_t rd;
	reg_idx_t rs1;
	reg_idx_t rs2;
	word_t    imm;
	logic     flush;
	logic     issue_ready;
	logic     commit_valid;
	reg_idx_t commit_rd;
	word_t    commit_value;

	// issued and not yet committed in program order
	instr_t      expq[$];
	// architectural state after every commit seen so far
	word_t       model [`NUM_REGS];
	logic [31:0] rng = 32'h29f1_b48f;
	int          mismatches = 0;
	int          protocol_errors = 0;
	int          timeouts = 0;
	int          issued = 0;
	int          total;

	ooo_core UUT (
		.clk          (clk),
		.rst          (rst),
		.issue        (issue),
		.op           (op),
		.rd           (rd),
		.rs1          (rs1),
		.rs2          (rs2),
		.imm          (imm),
		.flush        (flush),
		.issue_ready  (issue_ready),
		.commit_valid (commit_valid),
		.commit_rd    (commit_rd),
		.commit_value (commit_value)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// x0 reads zero whatever was committed to it
	function automatic word_t reg_read(input reg_idx_t r);
		return (r == '0) ? '0 : model[r];
	endfunction

	// sequential meaning of one instruction
	function automatic word_t expected_result(input instr_t ins);
		word_t a;
		word_t b;
		a = reg_read(ins.rs1);
		b = reg_read(ins.rs2);
		case (ins.op)
			op_add:  return a + b;
			op_sub:  return a - b;
			op_and:  return a & b;
			op_or:   return a | b;
			op_xor:  return a ^ b;
			default: return ins.imm;
		endcase
	endfunction

	// registers x0..x3 only, so most instructions depend on recent ones
	function automatic instr_t random_instr();
		instr_t ins;
		rng     = xorshift(rng);
		ins.op  = alu_op_t'(3'(rng % 6));
		ins.rd  = reg_idx_t'(rng[9:8]);
		ins.rs1 = reg_idx_t'(rng[17:16]);
		ins.rs2 = reg_idx_t'(rng[25:24]);
		rng     = xorshift(rng);
		ins.imm = rng;
		return ins;
	endfunction

	task automatic drive_instr(input instr_t ins);
		@(posedge clk);
		issue <= 1'b1;
		op    <= ins.op;
		rd    <= ins.rd;
		rs1   <= ins.rs1;
		rs2   <= ins.rs2;
		imm   <= ins.imm;
	endtask

	// wait for issue_ready and issue a burst sized so it cannot overrun the stations
	// each busy station holds an entry of expq
	task automatic issue_burst(input int n, input logic fixed, input instr_t ins);
		int waited;
		int budget;
		waited = 0;
		@(negedge clk);
		while (!issue_ready && waited < TIMEOUT) begin
			@(negedge clk);
			waited++;
		end
		if (!issue_ready) begin
			timeouts++;
			$display("issue_ready stayed low for %0d cycles at %0t", TIMEOUT, $time);
			return;
		end
		budget = `NUM_RS - expq.size();
		if (budget < 1) begin
			budget = 1;
		end
		if (budget > n) begin
			budget = n;
		end
		for (int i = 0; i < budget; i++) begin
			drive_instr(fixed ? ins : random_instr());
			issued++;
		end
		@(posedge clk);
		issue <= 1'b0;
	endtask

	task automatic drain();
		int waited;
		waited = 0;
		while (expq.size() != 0 && waited < TIMEOUT) begin
			@(negedge clk);
			waited++;
		end
		if (expq.size() != 0) begin
			timeouts++;
			$display("%0d instructions never committed, at %0t", expq.size(), $time);
		end
	endtask

	task automatic pulse_flush();
		@(posedge clk);
		flush <= 1'b1;
		@(posedge clk);
		flush <= 1'b0;
	endtask

	// reference model sees the values from before the edge
	always @(posedge clk) begin
		instr_t ins;
		word_t  exp;
		if (!rst) begin
			if (commit_valid) begin
				assert (expq.size() > 0) else begin
					protocol_errors++;
					$display("commit of x%0d with nothing outstanding at %0t",
						commit_rd, $time);
				end
				if (expq.size() > 0) begin
					ins = expq.pop_front();
					exp = expected_result(ins);
					assert (commit_rd == ins.rd && commit_value == exp) else begin
						mismatches++;
						$display("mismatch at %0t: commit x%0d = %h, expected x%0d = %h",
							$time, commit_rd, commit_value, ins.rd, exp);
					end
					if (ins.rd != '0) begin
						model[ins.rd] = exp;
					end
				end
			end
			// a flush drops uncommitted work and any issue of this cycle
			if (flush) begin
				expq.delete();
			end else if (issue && issue_ready) begin
				expq.push_back({op, rd, rs1, rs2, imm});
			end
		end
	end

	initial begin
		instr_t ins;
		for (int i = 0; i < `NUM_REGS; i++) begin
			model[i] = '0;
		end
		rst   = 1'b1;
		issue = 1'b0;
		op    = op_add;
		rd    = '0;
		rs1   = '0;
		rs2   = '0;
		imm   = '0;
		flush = 1'b0;
		repeat (2) @(posedge clk);
		rst <= 1'b0;

		// random program in bursts of dependent work
		while (issued < NUM_INSTR && timeouts == 0) begin
			issue_burst(1 + int'(rng[3:0]), 1'b0, ins);
		end
		drain();

		// flush with work in flight and continue from the committed state
		issue_burst(`NUM_RS, 1'b0, ins);
		pulse_flush();
		repeat (3) issue_burst(`NUM_RS, 1'b0, ins);
		drain();

		// x0 takes a commit but still reads zero
		ins = '{op: op_li, rd: 5'd0, rs1: 5'd0, rs2: 5'd0, imm: 32'h5555_aaaa};
		issue_burst(1, 1'b1, ins);
		ins = '{op: op_or, rd: 5'd1, rs1: 5'd0, rs2: 5'd0, imm: '0};
		issue_burst(1, 1'b1, ins);
		drain();

		total = mismatches + protocol_errors + timeouts + UUT.u_chk.fail_count;
		$display("errors: %0d mismatch, %0d protocol, %0d timeout, %0d assertion",
			mismatches, protocol_errors, timeouts, UUT.u_chk.fail_count);
		if (total == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

endmodule

// File: sim/ooo_core_chk.sv
`timescale 1ns/1ps

`include "ooo_params.svh"

module ooo_core_chk (
	input logic               clk,
	input logic               rst,
	input logic               issue,
	input logic               issue_ready,
	input logic               flush,
	input logic               commit_valid,
	input logic [`NUM_RS-1:0] grant
);

	// number of failed assertions for the closing report
	int fail_count = 0;

	// issue is only legal while the core can take it
	issue_protocol: assert property (@(posedge clk) disable iff (rst)
		issue |-> issue_ready)
	else begin
		fail_count++;
		$error("issue strobe while issue_ready is low");
	end

	// a flush empties the reorder buffer, so nothing retires right after it
	flush_quiet: assert property (@(posedge clk) disable iff (rst)
		flush |=> !commit_valid)
	else begin
		fail_count++;
		$error("commit_valid in the cycle after a flush");
	end

	// an empty core accepts work
	ready_after_reset: assert property (@(posedge clk)
		rst |=> issue_ready)
	else begin
		fail_count++;
		$error("issue_ready low after reset");
	end

	// at most one station drives the data bus
	grant_onehot: assert property (@(posedge clk) disable iff (rst)
		$onehot0(grant))
	else begin
		fail_count++;
		$error("more than one station granted");
	end

endmodule

bind ooo_core ooo_core_chk u_chk (
	.clk          (clk),
	.rst          (rst),
	.issue        (issue),
	.issue_ready  (issue_ready),
	.flush        (flush),
	.commit_valid (commit_valid),
	.grant        (rs_grant)
);

// File: source/ooo_core.sv
`timescale 1ns/1ps

`include "ooo_params.svh"

module ooo_core
	import isa_pkg::*, ooo_pkg::*;
(
	input  logic     clk,
	input  logic     rst,
	input  logic     issue,
	input  alu_op_t  op,
	input  reg_idx_t rd,
	input  reg_idx_t rs1,
	input  reg_idx_t rs2,
	input  word_t    imm,
	input  logic     flush,
	output logic     issue_ready,
	output logic     commit_valid,
	output reg_idx_t commit_rd,
	output word_t    commit_value
);

	// register file read
	reg_idx_t rf_rs1;
	reg_idx_t rf_rs2;
	logic     rs1_busy;
	logic     rs2_busy;
	word_t    rs1_value;
	word_t    rs2_value;
	rob_tag_t rs1_tag;
	rob_tag_t rs2_tag;

	// reorder buffer
	rob_tag_t tail_tag;
	logic     rob_full;
	logic     alloc;
	logic     rename;
	logic     rob_ready [`ROB_DEPTH];
	word_t    rob_value [`ROB_DEPTH];
	rob_tag_t commit_tag;

	// station load bus, shared by all stations
	logic [`NUM_RS-1:0] rs_load;
	alu_op_t            load_op;
	rob_tag_t           load_tag;
	word_t              load_a;
	logic               load_a_valid;
	rob_tag_t           load_a_tag;
	word_t              load_b;
	logic               load_b_valid;
	rob_tag_t           load_b_tag;

	// station status and results
	logic [`NUM_RS-1:0] rs_idle;
	logic [`NUM_RS-1:0] rs_done;
	logic [`NUM_RS-1:0] rs_grant;
	rob_tag_t           rs_result_tag [`NUM_RS];
	word_t              rs_result     [`NUM_RS];

	// common data bus
	logic     cdb_valid;
	rob_tag_t cdb_tag;
	word_t    cdb_value;

	dispatch u_dispatch (
		.issue        (issue),
		.op           (op),
		.rd           (rd),
		.rs1          (rs1),
		.rs2          (rs2),
		.imm          (imm),
		.issue_ready  (issue_ready),
		.rf_rs1       (rf_rs1),
		.rf_rs2       (rf_rs2),
		.rs1_busy     (rs1_busy),
		.rs2_busy     (rs2_busy),
		.rs1_value    (rs1_value),
		.rs2_value    (rs2_value),
		.rs1_tag      (rs1_tag),
		.rs2_tag      (rs2_tag),
		.tail_tag     (tail_tag),
		.rob_full     (rob_full),
		.cdb_valid    (cdb_valid),
		.cdb_tag      (cdb_tag),
		.cdb_value    (cdb_value),
		.rs_idle      (rs_idle),
		.alloc        (alloc),
		.rename       (rename),
		.rs_load      (rs_load),
		.load_op      (load_op),
		.load_tag     (load_tag),
		.load_a       (load_a),
		.load_a_valid (load_a_valid),
		.load_a_tag   (load_a_tag),
		.load_b       (load_b),
		.load_b_valid (load_b_valid),
		.load_b_tag   (load_b_tag)
	);

	for (genvar i = 0; i < `NUM_RS; i++) begin : g_rs
		res_station u_rs (
			.clk          (clk),
			.rst          (rst),
			.flush        (flush),
			.load         (rs_load[i]),
			.load_op      (load_op),
			.load_tag     (load_tag),
			.load_a       (load_a),
			.load_a_valid (load_a_valid),
			.load_a_tag   (load_a_tag),
			.load_b       (load_b),
			.load_b_valid (load_b_valid),
			.load_b_tag   (load_b_tag),
			.cdb_valid    (cdb_valid),
			.cdb_tag      (cdb_tag),
			.cdb_value    (cdb_value),
			.grant        (rs_grant[i]),
			.idle         (rs_idle[i]),
			.done         (rs_done[i]),
			.result_tag   (rs_result_tag[i]),
			.result       (rs_result[i])
		);
	end

	cdb_arbiter u_arbiter (
		.done       (rs_done),
		.result_tag (rs_result_tag),
		.result     (rs_result),
		.grant      (rs_grant),
		.cdb_valid  (cdb_valid),
		.cdb_tag    (cdb_tag),
		.cdb_value  (cdb_value)
	);

	rob u_rob (
		.clk          (clk),
		.rst          (rst),
		.flush        (flush),
		.alloc        (alloc),
		.alloc_rd     (rd),
		.tail_tag     (tail_tag),
		.full         (rob_full),
		.cdb_valid    (cdb_valid),
		.cdb_tag      (cdb_tag),
		.cdb_value    (cdb_value),
		.rob_ready    (rob_ready),
		.rob_value    (rob_value),
		.commit_valid (commit_valid),
		.commit_rd    (commit_rd),
		.commit_tag   (commit_tag),
		.commit_value (commit_value)
	);

	// rename uses the tail tag handed to dispatch in the same cycle
	regfile u_regfile (
		.clk          (clk),
		.rst          (rst),
		.flush        (flush),
		.rs1          (rf_rs1),
		.rs2          (rf_rs2),
		.rs1_busy     (rs1_busy),
		.rs2_busy     (rs2_busy),
		.rs1_value    (rs1_value),
		.rs2_value    (rs2_value),
		.rs1_tag      (rs1_tag),
		.rs2_tag      (rs2_tag),
		.rename       (rename),
		.rename_rd    (rd),
		.rename_tag   (tail_tag),
		.commit_valid (commit_valid),
		.commit_rd    (commit_rd),
		.commit_tag   (commit_tag),
		.commit_value (commit_value),
		.rob_ready    (rob_ready),
		.rob_value    (rob_value)
	);

endmodule

// File: source/cdb_arbiter.sv
`timescale 1ns/1ps

`include "ooo_params.svh"

module cdb_arbiter
	import isa_pkg::*, ooo_pkg::*;
(
	input  logic [`NUM_RS-1:0] done,
	input  rob_tag_t          result_tag [`NUM_RS],
	input  word_t             result     [`NUM_RS],
	output logic [`NUM_RS-1:0] grant,
	output logic              cdb_valid,
	output rob_tag_t          cdb_tag,
	output word_t             cdb_value
);

	// fixed priority, station 0 first
	// scan from the top so the lowest done index is the last to write
	always_comb begin
		grant     = '0;
		cdb_valid = 1'b0;
		cdb_tag   = '0;
		cdb_value = '0;
		for (int i = `NUM_RS - 1; i >= 0; i--) begin
			if (done[i]) begin
				grant     = '0;
				grant[i]  = 1'b1;
				cdb_valid = 1'b1;
				cdb_tag   = result_tag[i];
				cdb_value = result[i];
			end
		end
	end

endmodule

// File: source/res_station.sv
`timescale 1ns/1ps

module res_station
	import isa_pkg::*, ooo_pkg::*;
(
	input  logic     clk,
	input  logic     rst,
	input  logic     flush,
	// load from dispatch
	input  logic     load,
	input  alu_op_t  load_op,
	input  rob_tag_t load_tag,
	input  word_t    load_a,
	input  logic     load_a_valid,
	input  rob_tag_t load_a_tag,
	input  word_t    load_b,
	input  logic     load_b_valid,
	input  rob_tag_t load_b_tag,
	// operand snooping
	input  logic     cdb_valid,
	input  rob_tag_t cdb_tag,
	input  word_t    cdb_value,
	// bus arbitration
	input  logic     grant,
	output logic     idle,
	output logic     done,
	output rob_tag_t result_tag,
	output word_t    result
);

	rs_state_t state;
	alu_op_t   op;
	rob_tag_t  tag;
	word_t     a;
	word_t     b;
	logic      a_valid;
	logic      b_valid;
	rob_tag_t  a_tag;
	rob_tag_t  b_tag;

	function automatic word_t alu(alu_op_t f, word_t x, word_t y);
		case (f)
			op_add:  return x + y;
			op_sub:  return x - y;
			op_and:  return x & y;
			op_or:   return x | y;
			op_xor:  return x ^ y;
			// op_li, the immediate sits in operand a
			default: return x;
		endcase
	endfunction

	assign idle       = state == rs_idle;
	assign done       = state == rs_done;
	assign result_tag = tag;

	always_ff @(posedge clk) begin
		if (rst || flush) begin
			state <= rs_idle;
		end else begin
			case (state)
				rs_idle: begin
					if (load) begin
						state <= rs_wait;
					end
				end
				rs_wait: begin
					if (a_valid && b_valid) begin
						state <= rs_done;
					end
				end
				rs_done: begin
					// result goes out on the bus this cycle
					if (grant) begin
						state <= rs_idle;
					end
				end
				default: state <= rs_idle;
			endcase
		end
	end

	// operands and result, qualified by state
	always_ff @(posedge clk) begin
		if (state == rs_idle && load) begin
			op      <= load_op;
			tag     <= load_tag;
			a       <= load_a;
			a_valid <= load_a_valid;
			a_tag   <= load_a_tag;
			b       <= load_b;
			b_valid <= load_b_valid;
			b_tag   <= load_b_tag;
		end else if (state == rs_wait) begin
			if (a_valid && b_valid) begin
				result <= alu(op, a, b);
			end
			// capture a missing operand when its producer broadcasts
			if (!a_valid && cdb_valid && cdb_tag == a_tag) begin
				a       <= cdb_value;
				a_valid <= 1'b1;
			end
			if (!b_valid && cdb_valid && cdb_tag == b_tag) begin
				b       <= cdb_value;
				b_valid <= 1'b1;
			end
		end
	end

endmodule

// File: source/dispatch.sv
`timescale 1ns/1ps

`include "ooo_params.svh"

module dispatch
	import isa_pkg::*, ooo_pkg::*;
(
	input  logic              issue,
	input  alu_op_t           op,
	input  reg_idx_t          rd,
	input  reg_idx_t          rs1,
	input  reg_idx_t          rs2,
	input  word_t             imm,
	output logic              issue_ready,
	// register file read
	output reg_idx_t          rf_rs1,
	output reg_idx_t          rf_rs2,
	input  logic              rs1_busy,
	input  logic              rs2_busy,
	input  word_t             rs1_value,
	input  word_t             rs2_value,
	input  rob_tag_t          rs1_tag,
	input  rob_tag_t          rs2_tag,
	// reorder buffer
	input  rob_tag_t          tail_tag,
	input  logic              rob_full,
	// common data bus
	input  logic              cdb_valid,
	input  rob_tag_t          cdb_tag,
	input  word_t             cdb_value,
	// stations
	input  logic [`NUM_RS-1:0] rs_idle,
	output logic              alloc,
	output logic              rename,
	output logic [`NUM_RS-1:0] rs_load,
	output alu_op_t           load_op,
	output rob_tag_t          load_tag,
	output word_t             load_a,
	output logic              load_a_valid,
	output rob_tag_t          load_a_tag,
	output word_t             load_b,
	output logic              load_b_valid,
	output rob_tag_t          load_b_tag
);

	logic [`NUM_RS-1:0] free_sel;
	logic               accept;

	assign issue_ready = !rob_full && |rs_idle;
	assign accept      = issue && issue_ready;

	assign rf_rs1 = rs1;
	assign rf_rs2 = rs2;

	// x0 is never renamed, it keeps reading zero
	assign alloc    = accept;
	assign rename   = accept && rd != '0;
	assign rs_load  = accept ? free_sel : '0;
	assign load_op  = op;
	assign load_tag = tail_tag;

	// lowest idle station wins
	always_comb begin
		free_sel = '0;
		for (int i = `NUM_RS - 1; i >= 0; i--) begin
			if (rs_idle[i]) begin
				free_sel    = '0;
				free_sel[i] = 1'b1;
			end
		end
	end

	// operand a: register file, then bus of this cycle, else wait on the tag
	always_comb begin
		load_a_tag = rs1_tag;
		load_b_tag = rs2_tag;

		if (!rs1_busy) begin
			load_a       = rs1_value;
			load_a_valid = 1'b1;
		end else if (cdb_valid && cdb_tag == rs1_tag) begin
			load_a       = cdb_value;
			load_a_valid = 1'b1;
		end else begin
			load_a       = '0;
			load_a_valid = 1'b0;
		end

		// operand b, same order
		if (!rs2_busy) begin
			load_b       = rs2_value;
			load_b_valid = 1'b1;
		end else if (cdb_valid && cdb_tag == rs2_tag) begin
			load_b       = cdb_value;
			load_b_valid = 1'b1;
		end else begin
			load_b       = '0;
			load_b_valid = 1'b0;
		end

		// load immediate needs no registers
		if (op == op_li) begin
			load_a       = imm;
			load_a_valid = 1'b1;
			load_b       = '0;
			load_b_valid = 1'b1;
		end
	end

endmodule

// File: rob/rob.sv
`timescale 1ns/1ps

`include "ooo_params.svh"

module rob
	import isa_pkg::*, ooo_pkg::*;
(
	input  logic     clk,
	input  logic     rst,
	input  logic     flush,
	// allocation at issue
	input  logic     alloc,
	input  reg_idx_t alloc_rd,
	output rob_tag_t tail_tag,
	output logic     full,
	// result capture
	input  logic     cdb_valid,
	input  rob_tag_t cdb_tag,
	input  word_t    cdb_value,
	// per-entry state for operand forwarding
	output logic     rob_ready [`ROB_DEPTH],
	output word_t    rob_value [`ROB_DEPTH],
	// registered commit strobe
	output logic     commit_valid,
	output reg_idx_t commit_rd,
	output rob_tag_t commit_tag,
	output word_t    commit_value
);

	localparam int CNT_W = $clog2(`ROB_DEPTH + 1);

	rob_tag_t         head;
	rob_tag_t         tail;
	logic [CNT_W-1:0] count;
	// destination of each entry
	reg_idx_t         entry_rd [`ROB_DEPTH];

	logic do_alloc;
	logic do_retire;

	assign full     = count == CNT_W'(`ROB_DEPTH);
	assign tail_tag = tail;
	assign do_alloc = alloc && !full;
	// head retires once its result is in
	assign do_retire = count != '0 && rob_ready[head];

	// control state, flush acts like reset here
	always_ff @(posedge clk) begin
		if (rst || flush) begin
			head         <= '0;
			tail         <= '0;
			count        <= '0;
			commit_valid <= 1'b0;
			for (int i = 0; i < `ROB_DEPTH; i++) begin
				rob_ready[i] <= 1'b0;
			end
		end else begin
			commit_valid <= do_retire;
			if (do_retire) begin
				head <= head + 1'b1;
			end
			// ready stays set after retire until the slot is reused,
			// which keeps forwarding alive while the regfile writes back
			if (do_alloc) begin
				tail            <= tail + 1'b1;
				rob_ready[tail] <= 1'b0;
			end
			// the bus only carries tags of allocated entries
			if (cdb_valid) begin
				rob_ready[cdb_tag] <= 1'b1;
			end
			count <= count + CNT_W'(do_alloc) - CNT_W'(do_retire);
		end
	end

	// payload
	always_ff @(posedge clk) begin
		if (do_alloc) begin
			entry_rd[tail] <= alloc_rd;
		end
		if (cdb_valid) begin
			rob_value[cdb_tag] <= cdb_value;
		end
		if (do_retire) begin
			commit_rd    <= entry_rd[head];
			commit_tag   <= head;
			commit_value <= rob_value[head];
		end
	end

endmodule

// File: source/regfile.sv
`timescale 1ns/1ps

`include "ooo_params.svh"

module regfile
	import isa_pkg::*, ooo_pkg::*;
(
	input  logic     clk,
	input  logic     rst,
	input  logic     flush,
	// combinational operand reads
	input  reg_idx_t rs1,
	input  reg_idx_t rs2,
	output logic     rs1_busy,
	output logic     rs2_busy,
	output word_t    rs1_value,
	output word_t    rs2_value,
	output rob_tag_t rs1_tag,
	output rob_tag_t rs2_tag,
	// rename of the destination at issue
	input  logic     rename,
	input  reg_idx_t rename_rd,
	input  rob_tag_t rename_tag,
	// in-order commit from the reorder buffer
	input  logic     commit_valid,
	input  reg_idx_t commit_rd,
	input  rob_tag_t commit_tag,
	input  word_t    commit_value,
	// finished but uncommitted results
	input  logic     rob_ready [`ROB_DEPTH],
	input  word_t    rob_value [`ROB_DEPTH]
);

	// architectural values
	word_t    values [`NUM_REGS];
	// set while a newer producer is in flight
	logic     busy   [`NUM_REGS];
	// tag of the newest producer
	rob_tag_t tags   [`NUM_REGS];

	// forwarding hits when the producer has already finished
	logic rs1_fwd;
	logic rs2_fwd;

	assign rs1_fwd = busy[rs1] && rob_ready[tags[rs1]];
	assign rs2_fwd = busy[rs2] && rob_ready[tags[rs2]];

	always_comb begin
		// a finished producer makes the register look free
		rs1_busy  = busy[rs1] && !rs1_fwd;
		rs1_value = rs1_fwd ? rob_value[tags[rs1]] : values[rs1];
		rs1_tag   = tags[rs1];

		rs2_busy  = busy[rs2] && !rs2_fwd;
		rs2_value = rs2_fwd ? rob_value[tags[rs2]] : values[rs2];
		rs2_tag   = tags[rs2];
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < `NUM_REGS; i++) begin
				values[i] <= '0;
				busy[i]   <= 1'b0;
				tags[i]   <= '0;
			end
		end else begin
			// the committed value is architectural, always stored
			// busy only drops if no younger rename replaced the producer
			if (commit_valid && commit_rd != '0) begin
				values[commit_rd] <= commit_value;
				if (tags[commit_rd] == commit_tag) begin
					busy[commit_rd] <= 1'b0;
				end
			end

			if (flush) begin
				// all in-flight producers are gone, committed values stay
				for (int i = 0; i < `NUM_REGS; i++) begin
					busy[i] <= 1'b0;
				end
			end else if (rename) begin
				// comes after commit so a same-cycle rename keeps busy set
				busy[rename_rd] <= 1'b1;
				tags[rename_rd] <= rename_tag;
			end
		end
	end

endmodule

// File: common/ooo_pkg.sv
package ooo_pkg;

	`include "ooo_params.svh"

	// tag of a reorder buffer entry
	// also names the producer of a renamed register
	typedef logic [$clog2(`ROB_DEPTH)-1:0] rob_tag_t;

	// reservation station life cycle
	//   rs_idle  free, may be loaded by dispatch
	//   rs_wait  holds an instruction, waits for operands
	//   rs_done  result computed, waits for a bus grant
	typedef enum logic [1:0] {
		rs_idle = 2'd0,
		rs_wait = 2'd1,
		rs_done = 2'd2
	} rs_state_t;

endpackage

// File: common/isa_pkg.sv
package isa_pkg;

	`include "ooo_params.svh"

	// one architectural data word
	typedef logic [`XLEN-1:0] word_t;

	// register index, x0 reads as zero
	typedef logic [4:0] reg_idx_t;

	// integer ALU opcodes
	// every op but op_li reads rs1 and rs2
	typedef enum logic [2:0] {
		op_add = 3'd0,
		op_sub = 3'd1,
		op_and = 3'd2,
		op_or  = 3'd3,
		op_xor = 3'd4,
		// load immediate, rs1 and rs2 ignored
		op_li  = 3'd5
	} alu_op_t;

endpackage

// File: common/ooo_params.svh
`ifndef OOO_PARAMS_SVH
`define OOO_PARAMS_SVH

// datapath width in bits
`define XLEN 32

// architectural integer registers, x0 included
`define NUM_REGS 32

// reorder buffer entries, kept a power of two so the pointers wrap freely
`define ROB_DEPTH 8

// reservation stations
`define NUM_RS 4

`endif
